// File: bench/i3c_target_assertions.sv
// ****************************************
// Concurrent checks on bus event pulses,
// address valid and the ACK drive, bound
// to the target top level
// ****************************************

`timescale 1ns/1ns
`default_nettype none

module i3c_target_assertions
  import i3c_target_pkg::*;
(
  input logic      clk_i,
  input logic      rst_i,
  input logic      start_i,
  input logic      rstart_i,
  input logic      stop_i,
  input logic      addr_valid_i,
  input logic      sda_i,
  input rx_state_e rx_state_i
);

  a_start_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i |=> !start_i) else $error("START pulse longer than one cycle");

  a_rstart_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    rstart_i |=> !rstart_i) else $error("repeated START pulse longer than one cycle");

  a_stop_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    stop_i |=> !stop_i) else $error("STOP pulse longer than one cycle");

  a_events_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({start_i, rstart_i, stop_i})) else $error("bus events in the same cycle");

  a_addr_valid_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    addr_valid_i |=> !addr_valid_i) else $error("address valid longer than one cycle");

  // Target pulls SDA low only for the ACK bit
  a_sda_low_in_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    !sda_i |-> (rx_state_i == RX_ACK)) else $error("sda_o low outside the ACK state");

endmodule

bind i3c_target_top i3c_target_assertions u_assertions (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .start_i      (bus_start_o),
  .rstart_i     (bus_rstart_o),
  .stop_i       (bus_stop_o),
  .addr_valid_i (bus_addr_valid_o),
  .sda_i        (sda_o),
  .rx_state_i   (u_addr_receiver.state_q)
);

`default_nettype wire

// File: bench/tb_i3c_target.sv
// ****************************************
// Testbench for the I3C target front end:
// wired-AND SDA model, CSR and bus tasks,
// value checks, watchdog, closing line
// ****************************************

`timescale 1ns/1ns
`default_nettype none

`include "i3c_defs.svh"

module tb_i3c_target
  import i3c_target_pkg::*;
();

  localparam int half_clks = 8;
  localparam int num_random = 8;
  // Random and directed bytes plus the condition and glitch sequences
  localparam int num_bytes = num_random + 10;
  localparam int timeout_clks = num_bytes * 20 * half_clks + 4000;

  logic       clk_i;
  logic       rst_i;
  logic       scl_i;
  logic       sda_i;
  logic       sda_drv;
  logic       csr_wr_i;
  csr_addr_e  csr_addr_i;
  logic [7:0] csr_wdata_i;
  logic [7:0] csr_rdata_o;
  logic       sda_o;
  logic       bus_start_o;
  logic       bus_rstart_o;
  logic       bus_stop_o;
  logic [7:0] bus_addr_o;
  logic       bus_addr_valid_o;
  logic       xfer_in_progress_o;

  int unsigned n_start = 0;
  int unsigned n_rstart = 0;
  int unsigned n_stop = 0;
  int unsigned n_valid = 0;
  logic [7:0]  addr_seen = '0;
  int unsigned base_start;
  int unsigned base_rstart;
  int unsigned base_stop;
  int unsigned errors = 0;
  int unsigned checks = 0;
  logic        cfg_phy;
  logic [7:0]  cfg_sta;
  logic [7:0]  cfg_dyn;
  logic [7:0]  rnd;

  // Open-drain bus so the target can only pull SDA low
  assign sda_i = sda_drv & sda_o;

  i3c_target_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (bus_start_o) n_start <= n_start + 1;
      if (bus_rstart_o) n_rstart <= n_rstart + 1;
      if (bus_stop_o) n_stop <= n_stop + 1;
      if (bus_addr_valid_o) begin
        n_valid   <= n_valid + 1;
        addr_seen <= bus_addr_o;
      end
    end
  end

  initial begin
    repeat (timeout_clks) @(posedge clk_i);
    $display("Watchdog timeout: the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic csr_write(input csr_addr_e a, input logic [7:0] d);
    @(posedge clk_i);
    csr_wr_i    <= 1'b1;
    csr_addr_i  <= a;
    csr_wdata_i <= d;
    @(posedge clk_i);
    csr_wr_i <= 1'b0;
    case (a)
      CSR_CTRL: cfg_phy = d[0];
      CSR_STA_ADDR: cfg_sta = d;
      CSR_DYN_ADDR: cfg_dyn = d;
      default: ;
    endcase
  endtask

  task automatic csr_check(input csr_addr_e a, input logic [7:0] exp);
    @(posedge clk_i);
    csr_addr_i <= a;
    @(negedge clk_i);
    check_equal(csr_rdata_o, exp, $sformatf("readback of %s", a.name()));
  endtask

  // CTRL holds only phy_en, FILT only the 4-bit length
  function automatic logic [7:0] readback(input csr_addr_e a, input logic [7:0] d);
    case (a)
      CSR_CTRL: return {7'b0, d[0]};
      CSR_FILT: return {4'b0, d[3:0]};
      default: return d;
    endcase
  endfunction

  function automatic logic expect_match(input logic [7:0] b);
    logic [6:0] a;
    a = b[7:1];
    return cfg_phy && ((cfg_sta[7] && a == cfg_sta[6:0]) ||
                       (cfg_dyn[7] && a == cfg_dyn[6:0]) || a == `I3C_BROADCAST_ADDR);
  endfunction

  task automatic mark_events();
    base_start  = n_start;
    base_rstart = n_rstart;
    base_stop   = n_stop;
  endtask

  task automatic check_events(input int unsigned ds, dr, dp, input string what);
    check_equal(n_start - base_start, ds, {what, ": START pulses"});
    check_equal(n_rstart - base_rstart, dr, {what, ": repeated START pulses"});
    check_equal(n_stop - base_stop, dp, {what, ": STOP pulses"});
  endtask

  // SDA only moves while SCL is low except in START and STOP
  task automatic bus_start_cond();
    wait_clks(1);
    sda_drv <= 1'b0;
    wait_clks(half_clks);
    scl_i <= 1'b0;
  endtask

  task automatic bus_rstart_cond();
    wait_clks(4);
    sda_drv <= 1'b1;
    wait_clks(half_clks);
    scl_i <= 1'b1;
    wait_clks(half_clks);
    sda_drv <= 1'b0;
    wait_clks(half_clks);
    scl_i <= 1'b0;
  endtask

  task automatic bus_stop_cond();
    wait_clks(4);
    sda_drv <= 1'b0;
    wait_clks(4);
    scl_i <= 1'b1;
    wait_clks(half_clks);
    sda_drv <= 1'b1;
    wait_clks(2 * half_clks);
  endtask

  task automatic send_bit(input logic b);
    wait_clks(4);
    sda_drv <= b;
    wait_clks(4);
    scl_i <= 1'b1;
    wait_clks(half_clks);
    scl_i <= 1'b0;
  endtask

  task automatic ack_slot(output logic ack);
    wait_clks(4);
    sda_drv <= 1'b1;
    wait_clks(4);
    scl_i <= 1'b1;
    wait_clks(4);
    @(negedge clk_i);
    ack = sda_i;
    wait_clks(4);
    scl_i <= 1'b0;
  endtask

  task automatic address_transfer(input logic [7:0] b);
    int unsigned valid0;
    logic match;
    logic ack;
    match  = expect_match(b);
    valid0 = n_valid;
    bus_start_cond();
    for (int i = 7; i >= 0; i--) begin
      send_bit(b[i]);
    end
    ack_slot(ack);
    check_equal(n_valid - valid0, 1, "address valid pulses");
    check_equal(addr_seen, b, "captured address byte");
    check_equal(ack, !match, $sformatf("SDA at 9th SCL rise for %02h", b));
    // ACK released by now while the flag holds until STOP
    wait_clks(half_clks);
    @(negedge clk_i);
    check_equal(sda_o, 1'b1, "sda_o released after the ACK bit");
    check_equal(xfer_in_progress_o, match, "transfer flag before STOP");
    bus_stop_cond();
    @(negedge clk_i);
    check_equal(xfer_in_progress_o, 1'b0, "transfer flag after STOP");
  endtask

  initial begin
    rnd         = 8'($urandom(32'h0bdca1d9));
    rst_i       = 1'b1;
    scl_i       = 1'b1;
    sda_drv     = 1'b1;
    csr_wr_i    = 1'b0;
    csr_addr_i  = CSR_CTRL;
    csr_wdata_i = '0;
    cfg_phy     = 1'b1;
    cfg_sta     = 8'h00;
    cfg_dyn     = 8'h00;
    wait_clks(5);
    rst_i <= 1'b0;

    csr_check(CSR_CTRL, 8'h01);
    csr_check(CSR_STA_ADDR, 8'h00);
    csr_check(CSR_DYN_ADDR, 8'h00);
    csr_check(CSR_FILT, 8'h02);
    check_equal(sda_o, 1'b1, "sda_o after reset");
    check_equal(xfer_in_progress_o, 1'b0, "transfer flag after reset");

    for (int k = 0; k < 4; k++) begin
      rnd = 8'($urandom);
      csr_write(csr_addr_e'(k), rnd);
      csr_check(csr_addr_e'(k), readback(csr_addr_e'(k), rnd));
    end
    csr_write(CSR_CTRL, 8'h01);
    csr_write(CSR_FILT, 8'h02);
    csr_write(CSR_STA_ADDR, {1'b1, 7'h2A});
    csr_write(CSR_DYN_ADDR, {1'b1, 7'h35});

    mark_events();
    bus_start_cond();
    check_events(1, 0, 0, "START");
    mark_events();
    bus_rstart_cond();
    check_events(0, 1, 0, "repeated START");
    mark_events();
    bus_stop_cond();
    check_events(0, 0, 1, "STOP");

    for (int k = 0; k < num_random; k++) begin
      rnd = 8'($urandom);
      address_transfer(rnd);
    end
    address_transfer({7'h2A, 1'b0});
    address_transfer({7'h35, 1'b1});
    address_transfer({`I3C_BROADCAST_ADDR, 1'b0});
    address_transfer({7'h11, 1'b0});
    // Valid flags cleared
    csr_write(CSR_STA_ADDR, 8'h2A);
    csr_write(CSR_DYN_ADDR, 8'h35);
    address_transfer({7'h2A, 1'b0});
    address_transfer({7'h35, 1'b1});
    csr_write(CSR_CTRL, 8'h00);
    address_transfer({`I3C_BROADCAST_ADDR, 1'b0});
    csr_write(CSR_CTRL, 8'h01);

    // Glitch filter test with SCL held high
    csr_write(CSR_FILT, 8'h03);
    mark_events();
    wait_clks(1);
    sda_drv <= 1'b0;
    wait_clks(2);
    sda_drv <= 1'b1;
    wait_clks(2 * half_clks);
    check_events(0, 0, 0, "2 clock SDA glitch");
    sda_drv <= 1'b0;
    wait_clks(half_clks);
    sda_drv <= 1'b1;
    wait_clks(2 * half_clks);
    check_events(1, 0, 1, "8 clock SDA pulse");

    $display("Closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/addr_receiver.sv
// **************************************
// addr_receiver: address byte shift,
// address match, ACK drive and transfer
// in progress tracking
// **************************************

`timescale 1ns/1ns
`default_nettype none

`include "i3c_defs.svh"

module addr_receiver
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  bus_state_t  bus_i,
  input  bus_event_t  event_i,
  input  target_cfg_t cfg_i,
  output logic        sda_o,
  output addr_byte_t  bus_addr_o,
  output logic        bus_addr_valid_o,
  output logic        xfer_in_progress_o
);

  rx_state_e  state_q;
  logic [2:0] bit_cnt_q;
  addr_byte_t shift_q;
  addr_byte_t byte_nxt;
  logic       addr_match;
  logic       sda_q;
  logic       addr_valid_q;
  logic       xfer_q;

  // Byte as it stands once the current SDA bit is in
  assign byte_nxt = {shift_q[`I3C_ADDR_W-1:0], bus_i.sda};

  always_comb begin
    addr_match = 1'b0;
    if (cfg_i.phy_en) begin
      addr_match = (cfg_i.sta_valid && (byte_nxt[`I3C_ADDR_W:1] == cfg_i.sta_addr)) ||
                   (cfg_i.dyn_valid && (byte_nxt[`I3C_ADDR_W:1] == cfg_i.dyn_addr)) ||
                   (byte_nxt[`I3C_ADDR_W:1] == `I3C_BROADCAST_ADDR);
    end
  end

  // MSB first
  always_ff @(posedge clk_i) begin
    if ((state_q == RX_ADDR) && bus_i.scl_rise) begin
      shift_q <= byte_nxt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= RX_IDLE;
      bit_cnt_q    <= '0;
      sda_q        <= 1'b1;
      addr_valid_q <= 1'b0;
      xfer_q       <= 1'b0;
    end else begin
      addr_valid_q <= 1'b0;
      if (event_i.stop) begin
        state_q <= RX_IDLE;
        sda_q   <= 1'b1;
        xfer_q  <= 1'b0;
      end else if (event_i.start || event_i.rstart) begin
        state_q   <= RX_ADDR;
        bit_cnt_q <= '0;
        sda_q     <= 1'b1;
      end else begin
        unique case (state_q)
          RX_ADDR: begin
            if (bus_i.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == 3'd7) begin
                addr_valid_q <= 1'b1;
                state_q      <= addr_match ? RX_ACK : RX_IDLE;
              end
            end
          end
          RX_ACK: begin
            // First fall starts the ACK, the next one ends it
            if (bus_i.scl_fall) begin
              if (sda_q) begin
                sda_q  <= 1'b0;
                xfer_q <= 1'b1;
              end else begin
                sda_q   <= 1'b1;
                state_q <= RX_XFER;
              end
            end
          end
          RX_IDLE, RX_XFER: begin
          end
        endcase
      end
    end
  end

  assign sda_o              = sda_q;
  assign bus_addr_o         = shift_q;
  assign bus_addr_valid_o   = addr_valid_q;
  assign xfer_in_progress_o = xfer_q;

endmodule

`default_nettype wire

// File: design/bus_monitor.sv
// **************************************
// bus_monitor: SDA/SCL synchronizer and
// glitch filter, SCL edges, START,
// repeated START and STOP detection
// **************************************

`timescale 1ns/1ns
`default_nettype none

`include "i3c_defs.svh"

module bus_monitor
  import i3c_bus_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   scl_i,
  input  logic                   sda_i,
  input  logic [`I3C_FILT_W-1:0] filt_len_i,
  output bus_state_t             state_o,
  output bus_event_t             event_o
);

  // Line order in all 2-bit vectors
  localparam int unsigned scl_bit = 0;
  localparam int unsigned sda_bit = 1;

  logic [1:0] sync1_q;
  logic [1:0] sync2_q;
  logic [1:0] filt_q;
  logic [1:0] filt_nxt;
  logic [1:0] upd;
  logic [1:0][`I3C_FILT_W-1:0] cnt_q;

  logic scl_rise_q;
  logic scl_fall_q;
  logic busy_q;
  logic start_q;
  logic rstart_q;
  logic stop_q;
  logic start_nxt;
  logic rstart_nxt;
  logic stop_nxt;

  always_comb begin
    // New level accepted once it has been stable for filt_len+1 cycles
    for (int i = 0; i < 2; i++) begin
      upd[i]      = (sync2_q[i] != filt_q[i]) && (cnt_q[i] == filt_len_i);
      filt_nxt[i] = upd[i] ? sync2_q[i] : filt_q[i];
    end
    start_nxt  = upd[sda_bit] && !filt_nxt[sda_bit] && filt_nxt[scl_bit] && !busy_q;
    rstart_nxt = upd[sda_bit] && !filt_nxt[sda_bit] && filt_nxt[scl_bit] && busy_q;
    stop_nxt   = upd[sda_bit] && filt_nxt[sda_bit] && filt_nxt[scl_bit];
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // Idle bus has both lines high
      sync1_q    <= 2'b11;
      sync2_q    <= 2'b11;
      filt_q     <= 2'b11;
      cnt_q      <= '0;
      scl_rise_q <= 1'b0;
      scl_fall_q <= 1'b0;
      start_q    <= 1'b0;
      rstart_q   <= 1'b0;
      stop_q     <= 1'b0;
      busy_q     <= 1'b0;
    end else begin
      sync1_q <= {sda_i, scl_i};
      sync2_q <= sync1_q;
      filt_q  <= filt_nxt;
      for (int i = 0; i < 2; i++) begin
        if ((sync2_q[i] == filt_q[i]) || upd[i]) begin
          cnt_q[i] <= '0;
        end else begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
      scl_rise_q <= upd[scl_bit] && filt_nxt[scl_bit];
      scl_fall_q <= upd[scl_bit] && !filt_nxt[scl_bit];
      start_q    <= start_nxt;
      rstart_q   <= rstart_nxt;
      stop_q     <= stop_nxt;
      busy_q     <= (busy_q || start_nxt) && !stop_nxt;
    end
  end

  assign state_o.sda      = filt_q[sda_bit];
  assign state_o.scl      = filt_q[scl_bit];
  assign state_o.scl_rise = scl_rise_q;
  assign state_o.scl_fall = scl_fall_q;
  assign state_o.busy     = busy_q;

  assign event_o.start  = start_q;
  assign event_o.rstart = rstart_q;
  assign event_o.stop   = stop_q;

endmodule

`default_nettype wire

// File: design/i3c_bus_pkg.sv
// **************************************
// Bus side types: filtered line state,
// bus condition events, address byte
// **************************************

`default_nettype none

`include "i3c_defs.svh"

package i3c_bus_pkg;

  // Address byte as seen on the bus, RnW in bit 0
  typedef logic [`I3C_ADDR_W:0] addr_byte_t;

  typedef struct packed {
    logic sda;
    logic scl;
    logic scl_rise;
    logic scl_fall;
    logic busy;
  } bus_state_t;

  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_event_t;

endpackage

`default_nettype wire

// File: design/i3c_defs.svh
// **************************************
// Widths of bus addresses, CSR fields and
// the glitch filter length
// Broadcast address and CSR reset values
// **************************************

`ifndef I3C_DEFS_SVH
`define I3C_DEFS_SVH

// Bus address without the RnW bit
`define I3C_ADDR_W 7

// CSR access
`define I3C_CSR_ADDR_W 3
`define I3C_CSR_DATA_W 8

// Glitch filter length register
`define I3C_FILT_W 4

`define I3C_BROADCAST_ADDR 7'h7E

// CSR reset values
`define I3C_PHY_EN_RESET 1'b1
`define I3C_STA_ADDR_RESET 8'h00
`define I3C_DYN_ADDR_RESET 8'h00
`define I3C_FILT_RESET 4'd2

`endif

// File: design/i3c_target_pkg.sv
// **************************************
// Target side types: CSR addresses,
// packed configuration, receiver states
// **************************************

`default_nettype none

`include "i3c_defs.svh"

package i3c_target_pkg;

  typedef enum logic [`I3C_CSR_ADDR_W-1:0] {
    CSR_CTRL     = 0,
    CSR_STA_ADDR = 1,
    CSR_DYN_ADDR = 2,
    CSR_FILT     = 3
  } csr_addr_e;

  typedef struct packed {
    logic                   phy_en;
    logic                   sta_valid;
    logic [`I3C_ADDR_W-1:0] sta_addr;
    logic                   dyn_valid;
    logic [`I3C_ADDR_W-1:0] dyn_addr;
    logic [`I3C_FILT_W-1:0] filt_len;
  } target_cfg_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_ADDR,
    RX_ACK,
    RX_XFER
  } rx_state_e;

endpackage

`default_nettype wire

// File: design/i3c_target_top.sv
// **************************************
// i3c_target_top: bus monitor, CSR block
// and address receiver of the target
// **************************************

`timescale 1ns/1ns
`default_nettype none

`include "i3c_defs.svh"

module i3c_target_top
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       scl_i,
  input  logic                       sda_i,
  input  logic                       csr_wr_i,
  input  csr_addr_e                  csr_addr_i,
  input  logic [`I3C_CSR_DATA_W-1:0] csr_wdata_i,
  output logic [`I3C_CSR_DATA_W-1:0] csr_rdata_o,
  output logic                       sda_o,
  output logic                       bus_start_o,
  output logic                       bus_rstart_o,
  output logic                       bus_stop_o,
  output addr_byte_t                 bus_addr_o,
  output logic                       bus_addr_valid_o,
  output logic                       xfer_in_progress_o
);

  bus_state_t  bus_state;
  bus_event_t  bus_event;
  target_cfg_t cfg;

  bus_monitor u_bus_monitor (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .filt_len_i (cfg.filt_len),
    .state_o    (bus_state),
    .event_o    (bus_event)
  );

  target_config u_target_config (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .csr_wr_i    (csr_wr_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .cfg_o       (cfg)
  );

  addr_receiver u_addr_receiver (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .bus_i              (bus_state),
    .event_i            (bus_event),
    .cfg_i              (cfg),
    .sda_o              (sda_o),
    .bus_addr_o         (bus_addr_o),
    .bus_addr_valid_o   (bus_addr_valid_o),
    .xfer_in_progress_o (xfer_in_progress_o)
  );

  assign bus_start_o  = bus_event.start;
  assign bus_rstart_o = bus_event.rstart;
  assign bus_stop_o   = bus_event.stop;

endmodule

`default_nettype wire

// File: design/target_config.sv
// **************************************
// target_config: CSR set with write
// strobe, readback and packed config
// **************************************

`timescale 1ns/1ns
`default_nettype none

`include "i3c_defs.svh"

module target_config
  import i3c_target_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       csr_wr_i,
  input  csr_addr_e                  csr_addr_i,
  input  logic [`I3C_CSR_DATA_W-1:0] csr_wdata_i,
  output logic [`I3C_CSR_DATA_W-1:0] csr_rdata_o,
  output target_cfg_t                cfg_o
);

  logic                       phy_en_q;
  logic [`I3C_CSR_DATA_W-1:0] sta_q;
  logic [`I3C_CSR_DATA_W-1:0] dyn_q;
  logic [`I3C_FILT_W-1:0]     filt_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      phy_en_q <= `I3C_PHY_EN_RESET;
      sta_q    <= `I3C_STA_ADDR_RESET;
      dyn_q    <= `I3C_DYN_ADDR_RESET;
      filt_q   <= `I3C_FILT_RESET;
    end else if (csr_wr_i) begin
      unique case (csr_addr_i)
        CSR_CTRL: begin
          phy_en_q <= csr_wdata_i[0];
        end
        CSR_STA_ADDR: begin
          sta_q <= csr_wdata_i;
        end
        CSR_DYN_ADDR: begin
          dyn_q <= csr_wdata_i;
        end
        CSR_FILT: begin
          filt_q <= csr_wdata_i[`I3C_FILT_W-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // Readback, unused bits read as zero
  always_comb begin
    csr_rdata_o = '0;
    unique case (csr_addr_i)
      CSR_CTRL: begin
        csr_rdata_o[0] = phy_en_q;
      end
      CSR_STA_ADDR: begin
        csr_rdata_o = sta_q;
      end
      CSR_DYN_ADDR: begin
        csr_rdata_o = dyn_q;
      end
      CSR_FILT: begin
        csr_rdata_o[`I3C_FILT_W-1:0] = filt_q;
      end
      default: begin
      end
    endcase
  end

  // Bit 7 of each address register is its valid flag
  assign cfg_o.phy_en    = phy_en_q;
  assign cfg_o.sta_valid = sta_q[`I3C_ADDR_W];
  assign cfg_o.sta_addr  = sta_q[`I3C_ADDR_W-1:0];
  assign cfg_o.dyn_valid = dyn_q[`I3C_ADDR_W];
  assign cfg_o.dyn_addr  = dyn_q[`I3C_ADDR_W-1:0];
  assign cfg_o.filt_len  = filt_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the I3C target testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_i3c_target -Mdir obj_dir

# A failed run still prints its output, the search decides the status
out=$(./obj_dir/Vtb_i3c_target || true)
echo "$out"
echo "$out" | grep -q '^>>> PASS$'

// File: verilog.f
+incdir+design
design/i3c_bus_pkg.sv
design/i3c_target_pkg.sv
design/bus_monitor.sv
design/target_config.sv
design/addr_receiver.sv
design/i3c_target_top.sv
bench/i3c_target_assertions.sv
bench/tb_i3c_target.sv
